//--- logic/ctrl_params.svh
`ifndef CTRL_PARAMS_SVH
`define CTRL_PARAMS_SVH

// instruction layout
`define CTRL_OPCODE_W 6
`define CTRL_FIELD_W 10

// data bus to memory and port
`define CTRL_DATA_W 16

// commands buffered between decode and sequencer
`define CTRL_QUEUE_DEPTH 2

`endif

//--- logic/ctrl_pkg.sv
`default_nettype none

`include "ctrl_params.svh"

package ctrl_pkg;

    ////////////////////////////////////////////////////////////
    // encodings
    ////////////////////////////////////////////////////////////

    // octal opcode groups: alu 0x, memory 1x, port 2x
    typedef enum logic [`CTRL_OPCODE_W-1:0] {
        op_add   = 6'o00,
        op_sub   = 6'o01,
        op_and   = 6'o02,
        op_or    = 6'o03,
        op_xor   = 6'o04,
        op_addi  = 6'o05,
        op_load  = 6'o10,
        op_store = 6'o11,
        op_in    = 6'o20,
        op_out   = 6'o21
    } opcode_e;

    typedef enum logic [2:0] {
        alu_pass,
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor
    } alu_fn_e;

    typedef enum logic [2:0] {
        kind_alu,
        kind_load,
        kind_store,
        kind_port_in,
        kind_port_out,
        kind_trap
    } cmd_kind_e;

    typedef enum logic {
        fs_fetch,
        fs_hold
    } fetch_state_e;

    typedef enum logic [2:0] {
        ss_idle,
        ss_mem_wait,
        ss_port_up,
        ss_port_down,
        ss_done
    } seq_state_e;

    ////////////////////////////////////////////////////////////
    // bundles
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        opcode_e                   opcode;
        logic [`CTRL_FIELD_W-1:0]  field;
    } instr_t;

    typedef struct packed {
        alu_fn_e  fn;
        logic     use_imm;
        logic     reg_wr;
    } alu_ctrl_t;

    typedef struct packed {
        cmd_kind_e                 kind;
        opcode_e                   opcode;
        logic [`CTRL_FIELD_W-1:0]  field;
    } cmd_t;

    typedef struct packed {
        logic                      wr;
        logic [`CTRL_FIELD_W-1:0]  addr;
    } dmem_req_t;

    typedef struct packed {
        cmd_kind_e                 kind;
        opcode_e                   opcode;
        logic [`CTRL_DATA_W-1:0]   data;
    } retire_t;

endpackage

`default_nettype wire

//--- logic/fetch_decode.sv
`default_nettype none

module fetch_decode (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                instr_valid,
    input  wire ctrl_pkg::instr_t    instr,
    input  wire logic                cmd_ready,
    output logic                     instr_req,
    output logic                     cmd_valid,
    output ctrl_pkg::cmd_t           cmd,
    output logic                     alu_valid,
    output ctrl_pkg::alu_ctrl_t      alu_ctrl
);

    ctrl_pkg::fetch_state_e  state;
    ctrl_pkg::cmd_t          dec_cmd;
    ctrl_pkg::alu_ctrl_t     dec_alu;
    logic                    instr_take;

    assign instr_take = instr_req && instr_valid;

    ////////////////////////////////////////////////////////////
    // opcode decode
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        dec_cmd.kind    = ctrl_pkg::kind_trap;
        dec_cmd.opcode  = instr.opcode;
        dec_cmd.field   = instr.field;
        dec_alu.fn      = ctrl_pkg::alu_pass;
        dec_alu.use_imm = 1'b0;
        dec_alu.reg_wr  = 1'b0;
        case (instr.opcode)
            ctrl_pkg::op_add:   dec_alu.fn = ctrl_pkg::alu_add;
            ctrl_pkg::op_sub:   dec_alu.fn = ctrl_pkg::alu_sub;
            ctrl_pkg::op_and:   dec_alu.fn = ctrl_pkg::alu_and;
            ctrl_pkg::op_or:    dec_alu.fn = ctrl_pkg::alu_or;
            ctrl_pkg::op_xor:   dec_alu.fn = ctrl_pkg::alu_xor;
            ctrl_pkg::op_addi:
            begin
                dec_alu.fn      = ctrl_pkg::alu_add;
                dec_alu.use_imm = 1'b1;
            end
            ctrl_pkg::op_load:  dec_cmd.kind = ctrl_pkg::kind_load;
            ctrl_pkg::op_store: dec_cmd.kind = ctrl_pkg::kind_store;
            ctrl_pkg::op_in:    dec_cmd.kind = ctrl_pkg::kind_port_in;
            ctrl_pkg::op_out:   dec_cmd.kind = ctrl_pkg::kind_port_out;
            // undefined opcodes fall through as traps
            default:            dec_cmd.kind = ctrl_pkg::kind_trap;
        endcase
        if (dec_alu.fn != ctrl_pkg::alu_pass)
        begin
            dec_cmd.kind   = ctrl_pkg::kind_alu;
            dec_alu.reg_wr = 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // fetch fsm
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= ctrl_pkg::fs_fetch;
            instr_req <= 1'b0;
            cmd_valid <= 1'b0;
            alu_valid <= 1'b0;
        end
        else
        begin
            alu_valid <= 1'b0;
            case (state)
                ctrl_pkg::fs_fetch:
                begin
                    if (instr_take)
                    begin
                        state     <= ctrl_pkg::fs_hold;
                        instr_req <= 1'b0;
                        cmd_valid <= 1'b1;
                        alu_valid <= (dec_cmd.kind == ctrl_pkg::kind_alu);
                    end
                    else
                    begin
                        instr_req <= 1'b1;
                    end
                end
                ctrl_pkg::fs_hold:
                begin
                    // wait for a free queue slot
                    if (cmd_ready)
                    begin
                        state     <= ctrl_pkg::fs_fetch;
                        cmd_valid <= 1'b0;
                        instr_req <= 1'b1;
                    end
                end
                default: state <= ctrl_pkg::fs_fetch;
            endcase
        end
    end

    // decoded payload, qualified by cmd_valid and alu_valid
    always_ff @(posedge clk)
    begin
        if (instr_take)
        begin
            cmd      <= dec_cmd;
            alu_ctrl <= dec_alu;
        end
    end

    a_cmd_stable: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd));

endmodule

`default_nettype wire

//--- logic/cmd_queue.sv
`default_nettype none

`include "ctrl_params.svh"

module cmd_queue (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            cmd_valid,
    input  wire ctrl_pkg::cmd_t  cmd,
    input  wire logic            q_ready,
    output logic                 cmd_ready,
    output logic                 q_valid,
    output ctrl_pkg::cmd_t       q_cmd
);

    localparam int DEPTH = `CTRL_QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    ctrl_pkg::cmd_t    mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              wr_en;
    logic              rd_en;

    assign cmd_ready = (count != CNT_W'(DEPTH));
    assign q_valid   = (count != '0);
    assign q_cmd     = mem[rd_ptr];
    assign wr_en     = cmd_valid && cmd_ready;
    assign rd_en     = q_valid && q_ready;

    // storage
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_ptr] <= cmd;
        end
    end

    ////////////////////////////////////////////////////////////
    // pointers and fill level
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_en)
            begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en)
            begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the level unchanged
            if (wr_en && !rd_en)
            begin
                count <= count + 1'b1;
            end
            else if (rd_en && !wr_en)
            begin
                count <= count - 1'b1;
            end
        end
    end

    // when full the write slot is the head, so a write would change q_cmd
    a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
        count == CNT_W'(DEPTH) && !q_ready |=> $stable(q_cmd));

    a_no_read_empty: assert property (@(posedge clk) disable iff (!rst_n)
        count == '0 |=> $stable(rd_ptr));

endmodule

`default_nettype wire

//--- logic/mem_port_sequencer.sv
`default_nettype none

`include "ctrl_params.svh"

module mem_port_sequencer (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     q_valid,
    input  wire ctrl_pkg::cmd_t           q_cmd,
    input  wire logic                     dmem_valid,
    input  wire logic [`CTRL_DATA_W-1:0]  dmem_rdata,
    input  wire logic                     port_ack,
    input  wire logic [`CTRL_DATA_W-1:0]  port_rdata,
    output logic                          q_ready,
    output logic                          dmem_req_valid,
    output ctrl_pkg::dmem_req_t           dmem_req,
    output logic [`CTRL_DATA_W-1:0]       dmem_wdata,
    output logic                          port_strobe,
    output logic                          retire_valid,
    output ctrl_pkg::retire_t             retire
);

    ctrl_pkg::seq_state_e     state;
    ctrl_pkg::cmd_t           cur_cmd;
    logic [`CTRL_DATA_W-1:0]  ret_data;
    logic                     cmd_take;

    assign q_ready  = (state == ctrl_pkg::ss_idle);
    assign cmd_take = q_valid && q_ready;

    ////////////////////////////////////////////////////////////
    // outputs decoded from state and held command
    ////////////////////////////////////////////////////////////

    assign dmem_req_valid = (state == ctrl_pkg::ss_mem_wait);
    assign dmem_req.wr    = (cur_cmd.kind == ctrl_pkg::kind_store);
    assign dmem_req.addr  = cur_cmd.field;
    // store data is the operand field, zero-extended
    assign dmem_wdata     = {{(`CTRL_DATA_W - `CTRL_FIELD_W){1'b0}}, cur_cmd.field};

    assign port_strobe    = (state == ctrl_pkg::ss_port_up);

    assign retire_valid   = (state == ctrl_pkg::ss_done);
    assign retire.kind    = cur_cmd.kind;
    assign retire.opcode  = cur_cmd.opcode;
    assign retire.data    = ret_data;

    ////////////////////////////////////////////////////////////
    // sequencer fsm
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= ctrl_pkg::ss_idle;
        end
        else
        begin
            case (state)
                ctrl_pkg::ss_idle:
                begin
                    if (q_valid)
                    begin
                        case (q_cmd.kind)
                            ctrl_pkg::kind_load,
                            ctrl_pkg::kind_store:    state <= ctrl_pkg::ss_mem_wait;
                            ctrl_pkg::kind_port_in,
                            ctrl_pkg::kind_port_out: state <= ctrl_pkg::ss_port_up;
                            // alu and trap only need a retire record
                            default:                 state <= ctrl_pkg::ss_done;
                        endcase
                    end
                end
                ctrl_pkg::ss_mem_wait:
                begin
                    if (dmem_valid)
                    begin
                        state <= ctrl_pkg::ss_done;
                    end
                end
                ctrl_pkg::ss_port_up:
                begin
                    if (port_ack)
                    begin
                        state <= ctrl_pkg::ss_port_down;
                    end
                end
                ctrl_pkg::ss_port_down:
                begin
                    // four-phase return to zero
                    if (!port_ack)
                    begin
                        state <= ctrl_pkg::ss_done;
                    end
                end
                ctrl_pkg::ss_done: state <= ctrl_pkg::ss_idle;
                default:           state <= ctrl_pkg::ss_idle;
            endcase
        end
    end

    // command and returned data, valid only with the state above
    always_ff @(posedge clk)
    begin
        if (cmd_take)
        begin
            cur_cmd  <= q_cmd;
            ret_data <= '0;
        end
        else if (state == ctrl_pkg::ss_mem_wait && dmem_valid
                 && cur_cmd.kind == ctrl_pkg::kind_load)
        begin
            ret_data <= dmem_rdata;
        end
        else if (state == ctrl_pkg::ss_port_up && port_ack
                 && cur_cmd.kind == ctrl_pkg::kind_port_in)
        begin
            ret_data <= port_rdata;
        end
    end

    a_dmem_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_req_valid && !dmem_valid |=> dmem_req_valid && $stable(dmem_req));

    a_strobe_rise_ack_low: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(port_strobe) |-> !port_ack);

endmodule

`default_nettype wire

//--- logic/pipe_ctrl_top.sv
`default_nettype none

`include "ctrl_params.svh"

module pipe_ctrl_top (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    // instruction fetch
    output logic                          instr_req,
    input  wire logic                     instr_valid,
    input  wire ctrl_pkg::instr_t         instr,
    // datapath control
    output logic                          alu_valid,
    output ctrl_pkg::alu_ctrl_t           alu_ctrl,
    // data memory
    output logic                          dmem_req_valid,
    output ctrl_pkg::dmem_req_t           dmem_req,
    output logic [`CTRL_DATA_W-1:0]       dmem_wdata,
    input  wire logic                     dmem_valid,
    input  wire logic [`CTRL_DATA_W-1:0]  dmem_rdata,
    // i/o port
    output logic                          port_strobe,
    input  wire logic                     port_ack,
    input  wire logic [`CTRL_DATA_W-1:0]  port_rdata,
    // retire
    output logic                          retire_valid,
    output ctrl_pkg::retire_t             retire
);

    ////////////////////////////////////////////////////////////
    // stage links
    ////////////////////////////////////////////////////////////

    logic            cmd_valid;
    logic            cmd_ready;
    ctrl_pkg::cmd_t  cmd;
    logic            q_valid;
    logic            q_ready;
    ctrl_pkg::cmd_t  q_cmd;

    fetch_decode fetch_decode_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .cmd_ready   (cmd_ready),
        .instr_req   (instr_req),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .alu_valid   (alu_valid),
        .alu_ctrl    (alu_ctrl)
    );

    cmd_queue cmd_queue_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .q_ready   (q_ready),
        .cmd_ready (cmd_ready),
        .q_valid   (q_valid),
        .q_cmd     (q_cmd)
    );

    mem_port_sequencer mem_port_sequencer_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .q_valid        (q_valid),
        .q_cmd          (q_cmd),
        .dmem_valid     (dmem_valid),
        .dmem_rdata     (dmem_rdata),
        .port_ack       (port_ack),
        .port_rdata     (port_rdata),
        .q_ready        (q_ready),
        .dmem_req_valid (dmem_req_valid),
        .dmem_req       (dmem_req),
        .dmem_wdata     (dmem_wdata),
        .port_strobe    (port_strobe),
        .retire_valid   (retire_valid),
        .retire         (retire)
    );

endmodule

`default_nettype wire

//--- testbench/tb_pipe_ctrl.sv
`default_nettype none

`include "ctrl_params.svh"

module tb_pipe_ctrl;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_RECS      = 64;
    localparam int REC_W         = 6;
    localparam int COL_INSTR     = 0;
    localparam int COL_DELAY     = 1;
    localparam int COL_RDATA     = 2;
    localparam int COL_ALU       = 3;
    localparam int COL_KIND      = 4;
    localparam int COL_DATA      = 5;
    // sequencer, two queue slots and the decode register
    localparam int MAX_IN_FLIGHT = 4;

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic                       instr_req;
    logic                       instr_valid;
    ctrl_pkg::instr_t           instr;
    logic                       alu_valid;
    ctrl_pkg::alu_ctrl_t        alu_ctrl;
    logic                       dmem_req_valid;
    ctrl_pkg::dmem_req_t        dmem_req;
    logic [`CTRL_DATA_W-1:0]    dmem_wdata;
    logic                       dmem_valid;
    logic [`CTRL_DATA_W-1:0]    dmem_rdata;
    logic                       port_strobe;
    logic                       port_ack;
    logic [`CTRL_DATA_W-1:0]    port_rdata;
    logic                       retire_valid;
    ctrl_pkg::retire_t          retire;

    // word 0 is the record count, then six words per record
    logic [15:0]                words [0:MAX_RECS*REC_W];
    int                         num_recs      = 0;
    int                         max_delay     = 0;
    int                         cycle_limit   = 0;
    int                         cycle_cnt     = 0;
    int                         mismatch_cnt  = 0;
    int                         protocol_cnt  = 0;
    int                         retired_cnt   = 0;
    int                         accept_idx    = 0;
    int                         in_flight     = 0;
    int                         max_in_flight = 0;
    int                         stall_cnt     = 0;
    int                         alu_idx       = 0;
    logic                       alu_due       = 1'b0;
    logic                       timeout_hit   = 1'b0;
    ctrl_pkg::retire_t          exp_q [$];

    always #2 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
    end

    pipe_ctrl_top pipe_ctrl_top_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_req      (instr_req),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .alu_valid      (alu_valid),
        .alu_ctrl       (alu_ctrl),
        .dmem_req_valid (dmem_req_valid),
        .dmem_req       (dmem_req),
        .dmem_wdata     (dmem_wdata),
        .dmem_valid     (dmem_valid),
        .dmem_rdata     (dmem_rdata),
        .port_strobe    (port_strobe),
        .port_ack       (port_ack),
        .port_rdata     (port_rdata),
        .retire_valid   (retire_valid),
        .retire         (retire)
    );

    ////////////////////////////////////////////////////////////
    // record access
    ////////////////////////////////////////////////////////////

    function automatic logic [15:0] rec_word(input int idx, input int col);
        return words[1 + idx*REC_W + col];
    endfunction

    function automatic ctrl_pkg::instr_t rec_instr(input int idx);
        return ctrl_pkg::instr_t'(rec_word(idx, COL_INSTR));
    endfunction

    function automatic ctrl_pkg::cmd_kind_e rec_kind(input int idx);
        logic [15:0] w;
        w = rec_word(idx, COL_KIND);
        return ctrl_pkg::cmd_kind_e'(w[2:0]);
    endfunction

    function automatic ctrl_pkg::alu_ctrl_t exp_alu(input int idx);
        logic [15:0] w;
        w = rec_word(idx, COL_ALU);
        return ctrl_pkg::alu_ctrl_t'(w[4:0]);
    endfunction

    function automatic ctrl_pkg::retire_t exp_retire(input int idx);
        ctrl_pkg::retire_t r;
        ctrl_pkg::instr_t  ins;
        ins      = rec_instr(idx);
        r.kind   = rec_kind(idx);
        r.opcode = ins.opcode;
        r.data   = rec_word(idx, COL_DATA);
        return r;
    endfunction

    // alu and trap records never reach memory or port
    function automatic int next_io(input int idx);
        int i;
        i = idx;
        while (i < num_recs && (rec_kind(i) == ctrl_pkg::kind_alu
                                || rec_kind(i) == ctrl_pkg::kind_trap))
        begin
            i++;
        end
        return i;
    endfunction

    ////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_alu(input string name, input ctrl_pkg::alu_ctrl_t exp,
                             input ctrl_pkg::alu_ctrl_t act);
        if (act !== exp)
        begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            mismatch_cnt++;
        end
    endtask

    task automatic check_retire(input string name, input ctrl_pkg::retire_t exp,
                                input ctrl_pkg::retire_t act);
        if (act !== exp)
        begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            mismatch_cnt++;
        end
    endtask

    task automatic check_dmem(input string name, input ctrl_pkg::dmem_req_t exp,
                              input ctrl_pkg::dmem_req_t act);
        if (act !== exp)
        begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            mismatch_cnt++;
        end
    endtask

    task automatic check_data(input string name, input logic [`CTRL_DATA_W-1:0] exp,
                              input logic [`CTRL_DATA_W-1:0] act);
        if (act !== exp)
        begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            mismatch_cnt++;
        end
    endtask

    task automatic check_reset_low(input string name);
        logic [6:0] ctl;
        ctl = {instr_req, alu_valid, dmem_req_valid, port_strobe, retire_valid,
               pipe_ctrl_top_i.cmd_valid, pipe_ctrl_top_i.q_valid};
        if (ctl !== 7'b0)
        begin
            $display("ERROR %s: expected %b, actual %b", name, 7'b0, ctl);
            mismatch_cnt++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // memory and port responder
    ////////////////////////////////////////////////////////////

    task automatic serve_memory(input int idx);
        ctrl_pkg::instr_t    ins;
        ctrl_pkg::cmd_kind_e kind;
        ctrl_pkg::dmem_req_t exp_req;
        string               name;
        ins  = rec_instr(idx);
        kind = rec_kind(idx);
        name = $sformatf("rec %0d dmem_req", idx);
        if (kind != ctrl_pkg::kind_load && kind != ctrl_pkg::kind_store)
        begin
            $display("memory request arrived for record %0d, which is no load or store", idx);
            protocol_cnt++;
        end
        exp_req.wr   = (kind == ctrl_pkg::kind_store);
        exp_req.addr = ins.field;
        check_dmem(name, exp_req, dmem_req);
        if (exp_req.wr)
        begin
            check_data($sformatf("rec %0d dmem_wdata", idx),
                       {{(`CTRL_DATA_W - `CTRL_FIELD_W){1'b0}}, ins.field}, dmem_wdata);
        end
        repeat (int'(rec_word(idx, COL_DELAY)))
        begin
            @(posedge clk);
            if (!dmem_req_valid)
            begin
                $display("dmem_req_valid dropped before dmem_valid for record %0d", idx);
                protocol_cnt++;
            end
            check_dmem(name, exp_req, dmem_req);
        end
        dmem_valid <= 1'b1;
        dmem_rdata <= rec_word(idx, COL_RDATA);
        @(posedge clk);
        check_dmem(name, exp_req, dmem_req);
        dmem_valid <= 1'b0;
    endtask

    task automatic serve_port(input int idx);
        ctrl_pkg::cmd_kind_e kind;
        kind = rec_kind(idx);
        if (kind != ctrl_pkg::kind_port_in && kind != ctrl_pkg::kind_port_out)
        begin
            $display("port strobe arrived for record %0d, which is no port command", idx);
            protocol_cnt++;
        end
        repeat (int'(rec_word(idx, COL_DELAY)))
        begin
            @(posedge clk);
            if (!port_strobe)
            begin
                $display("port_strobe dropped before port_ack for record %0d", idx);
                protocol_cnt++;
            end
        end
        port_ack   <= 1'b1;
        port_rdata <= rec_word(idx, COL_RDATA);
        @(posedge clk);
        // strobe falls on the edge that sees the ack
        @(posedge clk);
        if (port_strobe)
        begin
            $display("port_strobe still high one cycle after port_ack, record %0d", idx);
            protocol_cnt++;
            while (port_strobe)
            begin
                @(posedge clk);
            end
        end
        port_ack   <= 1'b0;
        port_rdata <= '0;
    endtask

    initial
    begin : io_responder
        int idx;
        idx = 0;
        @(posedge rst_n);
        forever
        begin
            @(posedge clk);
            if (dmem_req_valid || port_strobe)
            begin
                idx = next_io(idx);
                if (idx >= num_recs)
                begin
                    $display("memory or port request with no such instruction outstanding");
                    protocol_cnt++;
                    while (dmem_req_valid || port_strobe)
                    begin
                        @(posedge clk);
                    end
                end
                else if (dmem_req_valid)
                begin
                    serve_memory(idx);
                    idx++;
                end
                else
                begin
                    serve_port(idx);
                    idx++;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // instruction responder
    ////////////////////////////////////////////////////////////

    initial
    begin : instr_feeder
        int wait_cycles;
        int idx;
        void'($urandom(32'h5946_e451));
        idx = 0;
        @(posedge rst_n);
        while (idx < num_recs)
        begin
            @(posedge clk);
            if (instr_req)
            begin
                wait_cycles = int'($urandom % 3);
                repeat (wait_cycles) @(posedge clk);
                instr_valid <= 1'b1;
                instr       <= rec_instr(idx);
                @(posedge clk);
                // instr_req holds until the take
                while (!instr_req)
                begin
                    @(posedge clk);
                end
                instr_valid <= 1'b0;
                idx++;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // monitor for alu control, retire order and back-pressure
    ////////////////////////////////////////////////////////////

    always @(posedge clk)
    begin : monitor
        logic alu_exp;
        if (rst_n)
        begin
            alu_exp = alu_due && (rec_kind(alu_idx) == ctrl_pkg::kind_alu);
            if (alu_valid !== alu_exp)
            begin
                $display("ERROR rec %0d alu_valid: expected %b, actual %b",
                         alu_idx, alu_exp, alu_valid);
                mismatch_cnt++;
            end
            // non-alu records expect alu_pass with both bits clear
            if (alu_due)
            begin
                check_alu($sformatf("rec %0d alu_ctrl", alu_idx), exp_alu(alu_idx), alu_ctrl);
            end
            alu_due = 1'b0;
            if (instr_req && instr_valid)
            begin
                exp_q.push_back(exp_retire(accept_idx));
                alu_due = 1'b1;
                alu_idx = accept_idx;
                accept_idx++;
                in_flight++;
            end
            if (retire_valid)
            begin
                if (exp_q.size() == 0)
                begin
                    $display("retire record seen with no instruction outstanding");
                    protocol_cnt++;
                end
                else
                begin
                    check_retire($sformatf("retire %0d", retired_cnt), exp_q.pop_front(), retire);
                end
                retired_cnt++;
                in_flight--;
            end
            if (in_flight > max_in_flight)
            begin
                max_in_flight = in_flight;
            end
            if (in_flight > MAX_IN_FLIGHT)
            begin
                $display("%0d instructions in flight, more than the pipeline holds", in_flight);
                protocol_cnt++;
            end
            if (pipe_ctrl_top_i.cmd_valid && !pipe_ctrl_top_i.cmd_ready)
            begin
                stall_cnt++;
                if (instr_req)
                begin
                    $display("instr_req high while decode waits on a full queue");
                    protocol_cnt++;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial
    begin : main
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        dmem_valid  = 1'b0;
        dmem_rdata  = '0;
        port_ack    = 1'b0;
        port_rdata  = '0;
        $readmemh("testbench/pipe_ctrl_testdata.txt", words);
        num_recs = int'(words[0]);
        if (num_recs < 1 || num_recs > MAX_RECS)
        begin
            $display("data file gives %0d records, outside 1 to %0d", num_recs, MAX_RECS);
            protocol_cnt++;
            num_recs = 0;
        end
        for (int i = 0; i < num_recs; i++)
        begin
            if (int'(rec_word(i, COL_DELAY)) > max_delay)
            begin
                max_delay = int'(rec_word(i, COL_DELAY));
            end
        end
        cycle_limit = num_recs * (max_delay + 12);

        repeat (2) @(posedge clk);
        check_reset_low("reset outputs during reset");
        rst_n <= 1'b1;
        @(posedge clk);
        check_reset_low("reset outputs first cycle after reset");
        @(posedge clk);
        if (!instr_req)
        begin
            $display("instr_req did not rise on the second cycle after reset release");
            protocol_cnt++;
        end

        // counters settle by the falling edge
        while (retired_cnt < num_recs && cycle_cnt < cycle_limit)
        begin
            @(negedge clk);
        end
        if (retired_cnt < num_recs)
        begin
            $display("run hung after %0d cycles waiting for retires, %0d of %0d seen",
                     cycle_cnt, retired_cnt, num_recs);
            timeout_hit = 1'b1;
        end
        // idle cycles catch any stray retire
        repeat (4) @(negedge clk);
        if (stall_cnt == 0 || max_in_flight < MAX_IN_FLIGHT)
        begin
            $display("the command queue never filled, back-pressure went untested");
            protocol_cnt++;
        end

        $display("errors: %0d mismatches, %0d protocol, %0d timeout",
                 mismatch_cnt, protocol_cnt, timeout_hit);
        if (mismatch_cnt == 0 && protocol_cnt == 0 && !timeout_hit)
        begin
            $display("*** TEST PASSED ***");
        end
        else
        begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/pipe_ctrl_testdata.txt
// columns: instr delay rdata alu_ctrl retire_kind retire_data
// the first word is the number of records
0016
0012 00 0000 05 0 0000  // add
04A5 00 0000 09 0 0000  // sub
0BFF 00 0000 0D 0 0000  // and
0D00 00 0000 11 0 0000  // or
12AA 00 0000 15 0 0000  // xor
147F 00 0000 07 0 0000  // addi
2040 03 BEEF 00 1 BEEF  // load
2555 01 7777 00 2 0000  // store, read data ignored
4003 02 1234 00 3 1234  // port in
4404 00 5A5A 00 4 0000  // port out, read data ignored
FC01 00 0000 00 5 0000  // illegal opcode 77
2081 0C A5A5 00 1 A5A5  // long load fills the queue
0001 00 0000 05 0 0000  // add
2400 00 0000 00 2 0000  // store
0402 00 0000 09 0 0000  // sub
20C3 0A 0F0F 00 1 0F0F  // load
40FF 08 CAFE 00 3 CAFE  // port in
1003 00 0000 15 0 0000  // xor
1C10 00 0000 00 5 0000  // illegal opcode 07
4555 05 0000 00 4 0000  // port out
17FF 00 0000 07 0 0000  // addi
2001 00 0001 00 1 0001  // load

//--- files.f
+incdir+logic
logic/ctrl_pkg.sv
logic/fetch_decode.sv
logic/cmd_queue.sv
logic/mem_port_sequencer.sv
logic/pipe_ctrl_top.sv
testbench/tb_pipe_ctrl.sv

//--- Makefile
SIM       ?= verilator
SIMFLAGS  ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_pipe_ctrl
FILELIST  ?= files.f
OBJDIR    ?= obj_dir
PASS_MSG  := *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# the exit status comes from the search for the pass line
run: compile
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
